// ==== tb.f ====
logic/core_pkg.sv
logic/l15_req_if.sv
logic/fetch_unit.sv
logic/lsu.sv
logic/l15_port_arbiter.sv
logic/core_l15_front.sv
verification/core_l15_checker.sv
verification/tb_core_l15_front.sv

// ==== Bender.yml ====
package:
  name: core_l15_front

sources:
  - logic/core_pkg.sv
  - logic/l15_req_if.sv
  - logic/fetch_unit.sv
  - logic/lsu.sv
  - logic/l15_port_arbiter.sv
  - logic/core_l15_front.sv
  - target: test
    files:
      - verification/core_l15_checker.sv
      - verification/tb_core_l15_front.sv

// ==== verification/tb_core_l15_front.sv ====
`timescale 1ns/1ps

module tb_core_l15_front;

	localparam int NUM_ROWS = 16;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * 200;  // Budget per table row

	typedef enum {FETCH_N, REDIRECT, MEMCMD, STALL_READY} row_kind_e;

	typedef struct
	{
		row_kind_e kind;
		core_pkg::mem_op_e op;
		logic [31:0] addr;
		logic [31:0] wdata;
		int count;           // Instructions to take
		logic [31:0] expected;  // Bit 0 is the expected misaligned flag
	} row_t;

	logic clk;
	logic nrst;
	logic [4:0] transducer_l15_rqtype;
	logic [2:0] transducer_l15_size;
	logic [31:0] transducer_l15_address;
	logic [63:0] transducer_l15_data;
	logic transducer_l15_val;
	logic l15_transducer_ack;
	logic l15_transducer_header_ack;
	logic l15_transducer_val;
	logic [63:0] l15_transducer_data_0;
	logic [63:0] l15_transducer_data_1;
	logic [3:0] l15_transducer_returntype;
	logic transducer_l15_req_ack;
	logic redirect_val;
	logic [31:0] redirect_pc;
	logic instr_ready;
	logic instr_val;
	logic [31:0] instr;
	logic [31:0] instr_pc;
	logic cmd_val;
	core_pkg::mem_op_e cmd_op;
	logic [31:0] cmd_addr;
	logic [31:0] cmd_wdata;
	logic cmd_ready;
	logic result_val;
	logic [31:0] result_data;
	logic result_misaligned;

	row_t rows [NUM_ROWS];
	logic [63:0] l15_mem [logic [28:0]];  // L1.5 model contents, written by stores
	logic [31:0] shadow [logic [29:0]];   // Expected memory, word addressed
	logic [31:0] exp_pc;
	int err_cnt;
	int mem_rq_cnt;  // Load/store requests seen by the model
	logic [4:0] last_mem_rqtype;
	logic [2:0] last_mem_size;
	logic [31:0] last_mem_addr;

	core_l15_front u_core_l15_front (.*);

	bind core_l15_front core_l15_checker u_checker (.*);

	// Fill pattern over the full byte address
	function automatic logic [31:0] pattern_word(input logic [31:0] a);
		return (a * 32'h0001_0003) ^ 32'hA5C3_96F1;
	endfunction

	function automatic logic [63:0] l15_read(input logic [28:0] idx);
		if (l15_mem.exists(idx))
			return l15_mem[idx];
		return {pattern_word({idx, 3'b100}), pattern_word({idx, 3'b000})};  // Little-endian words
	endfunction

	function automatic logic [31:0] shadow_word(input logic [31:0] a);
		if (shadow.exists(a[31:2]))
			return shadow[a[31:2]];
		return pattern_word({a[31:2], 2'b00});
	endfunction

	// Errors from the compare task, the L1.5 model and the bound assertions
	function automatic int total_errors();
		return err_cnt + u_core_l15_front.u_checker.fail_cnt;
	endfunction

	task automatic compare_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			err_cnt++;
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// L1.5 cache model, one request at a time
	task automatic run_l15_model();
		logic [4:0] rq;
		logic [2:0] sz;
		logic [31:0] addr;
		logic [63:0] wdata;
		logic [63:0] word;
		int lane;
		int nbytes;
		int wait_cycles;
		forever
		begin
			@(negedge clk);
			if (transducer_l15_val)
			begin
				rq = transducer_l15_rqtype;
				sz = transducer_l15_size;
				addr = transducer_l15_address;
				wdata = transducer_l15_data;
				wait_cycles = $urandom % 4;  // Late ack, 0 to 3 cycles
				repeat (wait_cycles) @(negedge clk);
				l15_transducer_ack = 1'b1;
				l15_transducer_header_ack = 1'b1;
				@(negedge clk);
				l15_transducer_ack = 1'b0;
				l15_transducer_header_ack = 1'b0;
				wait_cycles = $urandom % 4;  // Response 1 to 4 cycles after ack
				for (int c = 0; c <= wait_cycles; c++)
				begin
					if (c > 0)
						@(negedge clk);
					if (transducer_l15_val)
					begin
						err_cnt++;
						$display("A second request appeared at %0t while one was outstanding",
							$time);
					end
				end
				word = l15_read(addr[31:3]);
				case (rq)
					core_pkg::IMISS_RQ: l15_transducer_returntype = core_pkg::IFILL_RET;
					core_pkg::LOAD_RQ: l15_transducer_returntype = core_pkg::LOAD_RET;
					core_pkg::STORE_RQ:
					begin
						l15_transducer_returntype = core_pkg::ST_ACK;
						nbytes = (sz == core_pkg::SIZE_BYTE) ? 1 : 4;
						lane = (sz == core_pkg::SIZE_BYTE) ? addr[2:0] : {addr[2], 2'b00};
						for (int b = 0; b < 8; b++)
							if (b >= lane && b < lane + nbytes)
								word[8*b +: 8] = wdata[8*b +: 8];  // Only the addressed lanes
						l15_mem[addr[31:3]] = word;
					end
					default:
					begin
						err_cnt++;
						$display("Unknown request type %0d on the L1.5 port at %0t", rq, $time);
					end
				endcase
				if (rq != core_pkg::IMISS_RQ)
				begin
					mem_rq_cnt++;
					last_mem_rqtype = rq;
					last_mem_size = sz;
					last_mem_addr = addr;
				end
				l15_transducer_data_0 = word;
				l15_transducer_data_1 = ~word;
				l15_transducer_val = 1'b1;
				#1;
				if (!transducer_l15_req_ack)
				begin
					err_cnt++;
					$display("The response at %0t was not acknowledged", $time);
				end
				@(negedge clk);
				l15_transducer_val = 1'b0;
			end
		end
	endtask

	// Take n instructions in order, checked against the shadow memory
	task automatic take_instrs(input int n);
		int got;
		got = 0;
		while (got < n)
		begin
			@(negedge clk);
			instr_ready = 1'b1;
			if (instr_val)
			begin
				compare_value("instr_pc", instr_pc, exp_pc);
				compare_value("instr", instr, shadow_word(exp_pc));
				exp_pc = exp_pc + 32'd4;
				got++;
			end
		end
		@(negedge clk);
		instr_ready = 1'b0;  // Last one went at the edge before
	endtask

	task automatic redirect_to(input logic [31:0] target, input int n);
		logic done;
		done = 1'b0;
		while (!done)
		begin
			@(negedge clk);
			if (instr_val)
			begin
				instr_ready = 1'b1;  // Drain what the old path already delivered
				compare_value("instr_pc", instr_pc, exp_pc);
				compare_value("instr", instr, shadow_word(exp_pc));
				exp_pc = exp_pc + 32'd4;
			end
			else
			begin
				instr_ready = 1'b0;
				redirect_val = 1'b1;
				redirect_pc = target;
				done = 1'b1;
			end
		end
		@(negedge clk);
		redirect_val = 1'b0;
		exp_pc = target;
		take_instrs(n);
	endtask

	task automatic stall_and_take(input int n);
		int span;
		logic held;
		logic [31:0] held_instr;
		logic [31:0] held_pc;
		for (int i = 0; i < n; i++)
		begin
			span = 1 + ($urandom % 6);
			held = 1'b0;
			instr_ready = 1'b0;
			repeat (span)
			begin
				@(negedge clk);
				if (instr_val && held)
				begin
					compare_value("instr", instr, held_instr);
					compare_value("instr_pc", instr_pc, held_pc);
				end
				else if (instr_val)
				begin
					held = 1'b1;
					held_instr = instr;
					held_pc = instr_pc;
				end
			end
			take_instrs(1);
		end
	endtask

	task automatic run_mem_cmd(input row_t r);
		int rq_before;
		logic exp_mis;
		logic is_store;
		logic is_byte;
		logic [31:0] word;
		logic [7:0] bval;
		logic [31:0] exp_data;
		exp_mis = r.expected[0];
		is_store = (r.op == core_pkg::MEM_SB) || (r.op == core_pkg::MEM_SW);
		is_byte = (r.op == core_pkg::MEM_SB) || (r.op == core_pkg::MEM_LB) ||
			(r.op == core_pkg::MEM_LBU);
		word = shadow_word(r.addr);
		bval = word[8*r.addr[1:0] +: 8];
		case (r.op)
			core_pkg::MEM_LW: exp_data = word;
			core_pkg::MEM_LB: exp_data = {{24{bval[7]}}, bval};
			core_pkg::MEM_LBU: exp_data = {24'd0, bval};
			default: exp_data = 32'd0;  // Stores
		endcase
		rq_before = mem_rq_cnt;
		@(negedge clk);
		while (!cmd_ready)
			@(negedge clk);
		cmd_val = 1'b1;
		cmd_op = r.op;
		cmd_addr = r.addr;
		cmd_wdata = r.wdata;
		@(negedge clk);
		cmd_val = 1'b0;
		cmd_op = core_pkg::MEM_NONE;
		while (!result_val)
			@(negedge clk);
		compare_value("result_misaligned", result_misaligned, exp_mis);
		compare_value("load/store request count", mem_rq_cnt - rq_before, exp_mis ? 0 : 1);
		if (!exp_mis)
		begin
			compare_value("result_data", result_data, exp_data);
			compare_value("transducer_l15_rqtype", last_mem_rqtype,
				is_store ? core_pkg::STORE_RQ : core_pkg::LOAD_RQ);
			compare_value("transducer_l15_size", last_mem_size,
				is_byte ? core_pkg::SIZE_BYTE : core_pkg::SIZE_WORD);
			compare_value("transducer_l15_address", last_mem_addr, r.addr);
			if (r.op == core_pkg::MEM_SW)
				shadow[r.addr[31:2]] = r.wdata;
			else if (r.op == core_pkg::MEM_SB)
			begin
				word[8*r.addr[1:0] +: 8] = r.wdata[7:0];  // Neighbors keep their bytes
				shadow[r.addr[31:2]] = word;
			end
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the stimulus table did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		int errs_before;
		int rows_passed;
		int rows_failed;
		void'($urandom(32'h9d9d383d));
		rows[0] = '{FETCH_N, core_pkg::MEM_NONE, 32'h0, 32'h0, 6, 32'h0};
		rows[1] = '{MEMCMD, core_pkg::MEM_SW, 32'h2000, 32'hCAFE_F00D, 0, 32'h0};
		rows[2] = '{MEMCMD, core_pkg::MEM_LW, 32'h2000, 32'h0, 0, 32'h0};
		rows[3] = '{FETCH_N, core_pkg::MEM_NONE, 32'h0, 32'h0, 4, 32'h0};
		rows[4] = '{MEMCMD, core_pkg::MEM_SB, 32'h2005, 32'h0000_009C, 0, 32'h0};
		rows[5] = '{MEMCMD, core_pkg::MEM_LB, 32'h2005, 32'h0, 0, 32'h0};
		rows[6] = '{MEMCMD, core_pkg::MEM_LBU, 32'h2005, 32'h0, 0, 32'h0};
		rows[7] = '{MEMCMD, core_pkg::MEM_LW, 32'h2004, 32'h0, 0, 32'h0};  // Neighbors intact
		rows[8] = '{MEMCMD, core_pkg::MEM_LW, 32'h2006, 32'h0, 0, 32'h1};
		rows[9] = '{MEMCMD, core_pkg::MEM_SW, 32'h2003, 32'h1234_5678, 0, 32'h1};
		rows[10] = '{REDIRECT, core_pkg::MEM_NONE, 32'h3000, 32'h0, 4, 32'h0};
		rows[11] = '{STALL_READY, core_pkg::MEM_NONE, 32'h0, 32'h0, 8, 32'h0};
		rows[12] = '{MEMCMD, core_pkg::MEM_SB, 32'h2002, 32'h0000_007F, 0, 32'h0};
		rows[13] = '{MEMCMD, core_pkg::MEM_LB, 32'h2002, 32'h0, 0, 32'h0};
		rows[14] = '{FETCH_N, core_pkg::MEM_NONE, 32'h0, 32'h0, 5, 32'h0};
		rows[15] = '{REDIRECT, core_pkg::MEM_NONE, 32'h1800, 32'h0, 3, 32'h0};
		nrst = 1'b0;
		l15_transducer_ack = 1'b0;
		l15_transducer_header_ack = 1'b0;
		l15_transducer_val = 1'b0;
		l15_transducer_data_0 = '0;
		l15_transducer_data_1 = '0;
		l15_transducer_returntype = '0;
		redirect_val = 1'b0;
		redirect_pc = '0;
		instr_ready = 1'b0;
		cmd_val = 1'b0;
		cmd_op = core_pkg::MEM_NONE;
		cmd_addr = '0;
		cmd_wdata = '0;
		err_cnt = 0;
		mem_rq_cnt = 0;
		rows_passed = 0;
		rows_failed = 0;
		exp_pc = core_pkg::RESET_PC;
		repeat (8) @(negedge clk);
		nrst = 1'b1;
		fork
			run_l15_model();
		join_none
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			errs_before = total_errors();
			case (rows[i].kind)
				FETCH_N: take_instrs(rows[i].count);
				REDIRECT: redirect_to(rows[i].addr, rows[i].count);
				MEMCMD: run_mem_cmd(rows[i]);
				STALL_READY: stall_and_take(rows[i].count);
				default: ;
			endcase
			if (total_errors() == errs_before)
				rows_passed++;
			else
				rows_failed++;
			$display("Row %0d %s finished with %0d errors", i, rows[i].kind.name(),
				total_errors() - errs_before);
		end
		$display("Rows passed: %0d, rows failed: %0d", rows_passed, rows_failed);
		if (total_errors() == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== verification/core_l15_checker.sv ====
`timescale 1ns/1ps

module core_l15_checker
(
	input logic clk,
	input logic nrst,
	input logic [4:0] transducer_l15_rqtype,
	input logic [2:0] transducer_l15_size,
	input logic [31:0] transducer_l15_address,
	input logic [63:0] transducer_l15_data,
	input logic transducer_l15_val,
	input logic l15_transducer_ack,
	input logic instr_val,
	input logic instr_ready,
	input logic [31:0] instr,
	input logic [31:0] instr_pc,
	input logic result_val
);

	int fail_cnt = 0;  // Failed assertions so far

	// Request held unchanged until ack
	assert property (@(posedge clk) disable iff (!nrst)
		transducer_l15_val && !l15_transducer_ack |=> transducer_l15_val &&
		$stable(transducer_l15_rqtype) && $stable(transducer_l15_size) &&
		$stable(transducer_l15_address) && $stable(transducer_l15_data))
		else
		begin
			fail_cnt++;
			$error("L1.5 request changed before its ack");
		end

	assert property (@(posedge clk) !nrst |-> !transducer_l15_val)
		else
		begin
			fail_cnt++;
			$error("L1.5 request valid during reset");
		end

	// Output register holds under back-pressure
	assert property (@(posedge clk) disable iff (!nrst)
		instr_val && !instr_ready |=> instr_val && $stable(instr) && $stable(instr_pc))
		else
		begin
			fail_cnt++;
			$error("Instruction output changed while stalled");
		end

	assert property (@(posedge clk) disable iff (!nrst) result_val |=> !result_val)
		else
		begin
			fail_cnt++;
			$error("result_val high for two cycles");
		end

endmodule

// ==== logic/core_l15_front.sv ====
`timescale 1ns/1ps

module core_l15_front
(
	input logic clk,
	input logic nrst,

	// L1.5 request
	output logic [4:0] transducer_l15_rqtype,
	output logic [2:0] transducer_l15_size,
	output logic [core_pkg::XLEN-1:0] transducer_l15_address,
	output logic [core_pkg::L15_DATA_W-1:0] transducer_l15_data,
	output logic transducer_l15_val,
	input logic l15_transducer_ack,
	input logic l15_transducer_header_ack,

	// L1.5 response
	input logic l15_transducer_val,
	input logic [core_pkg::L15_DATA_W-1:0] l15_transducer_data_0,
	input logic [core_pkg::L15_DATA_W-1:0] l15_transducer_data_1,
	input logic [3:0] l15_transducer_returntype,
	output logic transducer_l15_req_ack,

	// Fetch side
	input logic redirect_val,
	input logic [core_pkg::XLEN-1:0] redirect_pc,
	input logic instr_ready,
	output logic instr_val,
	output logic [core_pkg::XLEN-1:0] instr,
	output logic [core_pkg::XLEN-1:0] instr_pc,

	// Load/store side
	input logic cmd_val,
	input core_pkg::mem_op_e cmd_op,
	input logic [core_pkg::XLEN-1:0] cmd_addr,
	input logic [core_pkg::XLEN-1:0] cmd_wdata,
	output logic cmd_ready,
	output logic result_val,
	output logic [core_pkg::XLEN-1:0] result_data,
	output logic result_misaligned
);

	l15_req_if if_fetch();  // Fetch unit to arbiter
	l15_req_if if_mem();    // LSU to arbiter

	fetch_unit u_fetch
	(
		.clk          (clk),
		.nrst         (nrst),
		.port         (if_fetch.peer),
		.redirect_val (redirect_val),
		.redirect_pc  (redirect_pc),
		.instr_ready  (instr_ready),
		.instr_val    (instr_val),
		.instr        (instr),
		.instr_pc     (instr_pc)
	);

	lsu u_lsu
	(
		.clk               (clk),
		.nrst              (nrst),
		.port              (if_mem.peer),
		.cmd_val           (cmd_val),
		.cmd_op            (cmd_op),
		.cmd_addr          (cmd_addr),
		.cmd_wdata         (cmd_wdata),
		.cmd_ready         (cmd_ready),
		.result_val        (result_val),
		.result_data       (result_data),
		.result_misaligned (result_misaligned)
	);

	l15_port_arbiter u_arb
	(
		.clk                       (clk),
		.nrst                      (nrst),
		.fetch                     (if_fetch.arb),
		.mem                       (if_mem.arb),
		.transducer_l15_rqtype     (transducer_l15_rqtype),
		.transducer_l15_size       (transducer_l15_size),
		.transducer_l15_address    (transducer_l15_address),
		.transducer_l15_data       (transducer_l15_data),
		.transducer_l15_val        (transducer_l15_val),
		.transducer_l15_req_ack    (transducer_l15_req_ack),
		.l15_transducer_ack        (l15_transducer_ack),
		.l15_transducer_header_ack (l15_transducer_header_ack),
		.l15_transducer_val        (l15_transducer_val),
		.l15_transducer_data_0     (l15_transducer_data_0),
		.l15_transducer_data_1     (l15_transducer_data_1),
		.l15_transducer_returntype (l15_transducer_returntype)
	);

endmodule

// ==== logic/l15_port_arbiter.sv ====
`timescale 1ns/1ps

module l15_port_arbiter
(
	input logic clk,
	input logic nrst,
	l15_req_if.arb fetch,
	l15_req_if.arb mem,
	output logic [4:0] transducer_l15_rqtype,
	output logic [2:0] transducer_l15_size,
	output logic [core_pkg::XLEN-1:0] transducer_l15_address,
	output logic [core_pkg::L15_DATA_W-1:0] transducer_l15_data,
	output logic transducer_l15_val,
	output logic transducer_l15_req_ack,
	input logic l15_transducer_ack,
	input logic l15_transducer_header_ack,
	input logic l15_transducer_val,
	input logic [core_pkg::L15_DATA_W-1:0] l15_transducer_data_0,
	input logic [core_pkg::L15_DATA_W-1:0] l15_transducer_data_1,
	input logic [3:0] l15_transducer_returntype
);

	core_pkg::arb_state_e state;
	logic [1:0] fetch_cnt;  // Fetch misses acked, not yet answered
	logic fetch_acked;
	logic fetch_answered;
	logic mem_answered;
	logic fetch_hold;  // Fetch request on the port still waiting for ack

	assign fetch_acked = (state == core_pkg::ARB_INSTR) && fetch.val && l15_transducer_ack;
	assign fetch_answered = fetch.resp_val && fetch.req_ack;
	assign mem_answered = mem.resp_val && mem.req_ack;
	assign fetch_hold = fetch.val && !l15_transducer_ack;

	// Response payload goes to both, only val is steered
	assign fetch.resp_data_0 = l15_transducer_data_0;
	assign fetch.resp_data_1 = l15_transducer_data_1;
	assign fetch.resp_returntype = core_pkg::l15_rettype_e'(l15_transducer_returntype);
	assign mem.resp_data_0 = l15_transducer_data_0;
	assign mem.resp_data_1 = l15_transducer_data_1;
	assign mem.resp_returntype = core_pkg::l15_rettype_e'(l15_transducer_returntype);

	always_comb
	begin
		// Fetch fields by default, kept in ARB_WAIT too
		transducer_l15_rqtype = fetch.rqtype;
		transducer_l15_size = fetch.size;
		transducer_l15_address = fetch.address;
		transducer_l15_data = fetch.data;
		transducer_l15_val = 1'b0;
		transducer_l15_req_ack = 1'b0;
		fetch.ack = 1'b0;
		fetch.header_ack = 1'b0;
		fetch.resp_val = 1'b0;
		mem.ack = 1'b0;
		mem.header_ack = 1'b0;
		mem.resp_val = 1'b0;
		case (state)
			core_pkg::ARB_INSTR:
			begin
				transducer_l15_val = fetch.val;
				fetch.ack = l15_transducer_ack;
				fetch.header_ack = l15_transducer_header_ack;
				fetch.resp_val = l15_transducer_val;
				transducer_l15_req_ack = fetch.req_ack;
			end
			core_pkg::ARB_WAIT:
			begin
				// No new requests, late fills still reach fetch
				fetch.resp_val = l15_transducer_val;
				transducer_l15_req_ack = fetch.req_ack;
			end
			core_pkg::ARB_MEM:
			begin
				transducer_l15_rqtype = mem.rqtype;
				transducer_l15_size = mem.size;
				transducer_l15_address = mem.address;
				transducer_l15_data = mem.data;
				transducer_l15_val = mem.val;
				mem.ack = l15_transducer_ack;
				mem.header_ack = l15_transducer_header_ack;
				mem.resp_val = l15_transducer_val;
				transducer_l15_req_ack = mem.req_ack;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state <= core_pkg::ARB_INSTR;
			fetch_cnt <= 2'd0;
		end
		else
		begin
			if (fetch_acked && !fetch_answered)
				fetch_cnt <= fetch_cnt + 2'd1;
			else if (fetch_answered && !fetch_acked)
				fetch_cnt <= fetch_cnt - 2'd1;

			case (state)
				core_pkg::ARB_INSTR:
				begin
					// Never pull a fetch request off the port before its ack
					if (mem.val && !fetch_hold)
						state <= core_pkg::ARB_WAIT;
				end
				core_pkg::ARB_WAIT:
				begin
					if (fetch_cnt == 2'd0)
						state <= core_pkg::ARB_MEM;
				end
				core_pkg::ARB_MEM:
				begin
					if (mem_answered)
						state <= core_pkg::ARB_INSTR;
				end
				default: state <= core_pkg::ARB_INSTR;
			endcase
		end
	end

endmodule

// ==== logic/lsu.sv ====
`timescale 1ns/1ps

module lsu
(
	input logic clk,
	input logic nrst,
	l15_req_if.peer port,
	input logic cmd_val,
	input core_pkg::mem_op_e cmd_op,
	input logic [core_pkg::XLEN-1:0] cmd_addr,
	input logic [core_pkg::XLEN-1:0] cmd_wdata,
	output logic cmd_ready,
	output logic result_val,
	output logic [core_pkg::XLEN-1:0] result_data,
	output logic result_misaligned
);

	typedef enum logic [1:0]
	{
		IDLE = 2'd0,
		REQ  = 2'd1,  // Request on the port until ack
		RESP = 2'd2   // Waiting for load data or store ack
	} lsu_state_e;

	lsu_state_e state;
	core_pkg::mem_op_e op_q;  // Captured command
	logic [core_pkg::XLEN-1:0] addr_q;
	logic [core_pkg::XLEN-1:0] wdata_q;
	logic cmd_fire;
	logic cmd_misaligned;
	logic is_byte;
	logic is_store;
	logic done;
	logic [2:0] lane;  // Byte offset inside the 64-bit word
	logic [core_pkg::L15_DATA_W-1:0] store_src;
	logic [core_pkg::L15_DATA_W-1:0] load_word;
	logic [7:0] load_byte;
	logic [core_pkg::XLEN-1:0] load_result;

	assign cmd_ready = (state == IDLE);
	// No-op commands are accepted and dropped
	assign cmd_fire = cmd_val && cmd_ready && (cmd_op != core_pkg::MEM_NONE);
	// Word access must be 4-byte aligned
	assign cmd_misaligned = ((cmd_op == core_pkg::MEM_LW) || (cmd_op == core_pkg::MEM_SW)) &&
		(cmd_addr[1:0] != 2'b00);

	assign is_byte = (op_q == core_pkg::MEM_LB) || (op_q == core_pkg::MEM_LBU) ||
		(op_q == core_pkg::MEM_SB);
	assign is_store = (op_q == core_pkg::MEM_SB) || (op_q == core_pkg::MEM_SW);
	assign lane = is_byte ? addr_q[2:0] : {addr_q[2], 2'b00};

	// Store data moved into its lane
	assign store_src = is_byte ? {{(core_pkg::L15_DATA_W-8){1'b0}}, wdata_q[7:0]}
		: {{(core_pkg::L15_DATA_W-core_pkg::XLEN){1'b0}}, wdata_q};
	assign port.data = store_src << {lane, 3'b000};
	assign port.address = addr_q;
	assign port.val = (state == REQ);
	assign port.req_ack = port.resp_val;  // Only routed here in ARB_MEM

	always_comb
	begin
		if (is_store)
			port.rqtype = core_pkg::STORE_RQ;
		else
			port.rqtype = core_pkg::LOAD_RQ;
		if (is_byte)
			port.size = core_pkg::SIZE_BYTE;
		else
			port.size = core_pkg::SIZE_WORD;
	end

	assign done = (state == RESP) && port.resp_val &&
		((port.resp_returntype == core_pkg::LOAD_RET) ||
		(port.resp_returntype == core_pkg::ST_ACK));

	// Addressed lane down to bit 0
	assign load_word = port.resp_data_0 >> {lane, 3'b000};
	assign load_byte = load_word[7:0];

	always_comb
	begin
		case (op_q)
			core_pkg::MEM_LB: load_result = {{(core_pkg::XLEN-8){load_byte[7]}}, load_byte};
			core_pkg::MEM_LBU: load_result = {{(core_pkg::XLEN-8){1'b0}}, load_byte};
			core_pkg::MEM_LW: load_result = load_word[core_pkg::XLEN-1:0];
			default: load_result = '0;  // Stores return zero
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state <= IDLE;
			result_val <= 1'b0;
		end
		else
		begin
			result_val <= 1'b0;  // One-cycle pulse
			case (state)
				IDLE:
				begin
					if (cmd_fire && cmd_misaligned)
						result_val <= 1'b1;  // Fails at once, nothing sent
					else if (cmd_fire)
						state <= REQ;
				end
				REQ:
				begin
					if (port.ack)
						state <= RESP;
				end
				RESP:
				begin
					if (done)
					begin
						result_val <= 1'b1;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Command capture and result payload
	always_ff @(posedge clk)
	begin
		if (cmd_fire)
		begin
			op_q <= cmd_op;
			addr_q <= cmd_addr;
			wdata_q <= cmd_wdata;
		end
		if (cmd_fire && cmd_misaligned)
		begin
			result_data <= '0;
			result_misaligned <= 1'b1;
		end
		else if (done)
		begin
			result_data <= load_result;
			result_misaligned <= 1'b0;
		end
	end

endmodule

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit
(
	input logic clk,
	input logic nrst,
	l15_req_if.peer port,
	input logic redirect_val,
	input logic [core_pkg::XLEN-1:0] redirect_pc,
	input logic instr_ready,
	output logic instr_val,
	output logic [core_pkg::XLEN-1:0] instr,
	output logic [core_pkg::XLEN-1:0] instr_pc
);

	logic [core_pkg::XLEN-1:0] pc;        // Next address to fetch
	logic [core_pkg::XLEN-1:0] pc_next;   // pc after a possible redirect
	logic [core_pkg::XLEN-1:0] req_addr;  // Address of the miss in flight
	logic [core_pkg::XLEN-1:0] fill_word;
	logic req_val;    // Miss presented, no ack yet
	logic wait_resp;  // Miss acked, fill not back
	logic discard;    // Fill in flight belongs to an old path
	logic take;
	logic fill;
	logic drop;
	logic out_busy;
	logic issue;

	assign take = instr_val && instr_ready;
	assign fill = wait_resp && port.resp_val &&
		(port.resp_returntype == core_pkg::IFILL_RET);
	assign drop = discard || redirect_val;  // Fill is acked but not kept
	// Output register still occupied after this edge
	assign out_busy = (instr_val && !take) || (fill && !drop);
	// Start a miss only when nothing stays in flight and the output is free
	assign issue = !req_val && !(wait_resp && !fill) && !out_busy;
	assign pc_next = redirect_val ? redirect_pc : pc;

	// Word picked by address bit 2, little-endian lanes
	assign fill_word = req_addr[2] ? port.resp_data_0[core_pkg::L15_DATA_W-1 -: core_pkg::XLEN]
		: port.resp_data_0[core_pkg::XLEN-1:0];

	// Instruction miss request
	assign port.rqtype = core_pkg::IMISS_RQ;
	assign port.size = core_pkg::SIZE_WORD;
	assign port.address = req_addr;
	assign port.data = '0;  // No write data on a fetch
	assign port.val = req_val;
	assign port.req_ack = port.resp_val;  // Routed responses are always taken

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			pc <= core_pkg::RESET_PC;
			req_val <= 1'b0;
			wait_resp <= 1'b0;
			discard <= 1'b0;
			instr_val <= 1'b0;
		end
		else
		begin
			if (issue)
				pc <= pc_next + 32'd4;  // Sequential path
			else
				pc <= pc_next;

			if (issue)
				req_val <= 1'b1;
			else if (req_val && port.ack)
				req_val <= 1'b0;

			if (req_val && port.ack)
				wait_resp <= 1'b1;
			else if (fill)
				wait_resp <= 1'b0;

			// Mark the outstanding miss stale on redirect
			if (redirect_val && (req_val || (wait_resp && !fill)))
				discard <= 1'b1;
			else if (fill)
				discard <= 1'b0;

			if (fill && !drop)
				instr_val <= 1'b1;
			else if (take)
				instr_val <= 1'b0;
		end
	end

	// Request address and instruction output register
	always_ff @(posedge clk)
	begin
		if (issue)
			req_addr <= pc_next;
		if (fill && !drop)
		begin
			instr <= fill_word;
			instr_pc <= req_addr;
		end
	end

endmodule

// ==== logic/l15_req_if.sv ====
`timescale 1ns/1ps

// One peer's view of the L1.5 port
interface l15_req_if;

	// Request, held with val until ack
	core_pkg::l15_rqtype_e rqtype;
	logic [2:0] size;
	logic [core_pkg::XLEN-1:0] address;
	logic [core_pkg::L15_DATA_W-1:0] data;
	logic val;
	logic ack;
	logic header_ack;

	// Response, one cycle of resp_val answered by req_ack
	logic resp_val;
	logic [core_pkg::L15_DATA_W-1:0] resp_data_0;
	logic [core_pkg::L15_DATA_W-1:0] resp_data_1;
	core_pkg::l15_rettype_e resp_returntype;
	logic req_ack;

	modport peer
	(
		output rqtype, size, address, data, val, req_ack,
		input ack, header_ack, resp_val, resp_data_0, resp_data_1, resp_returntype
	);

	modport arb
	(
		input rqtype, size, address, data, val, req_ack,
		output ack, header_ack, resp_val, resp_data_0, resp_data_1, resp_returntype
	);

endinterface

// ==== logic/core_pkg.sv ====
package core_pkg;

	// Datapath widths
	localparam int XLEN       = 32;  // Instructions, addresses, load/store data
	localparam int L15_DATA_W = 64;  // One L1.5 data word

	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;  // First fetch after reset

	// L1.5 size field codes
	localparam logic [2:0] SIZE_BYTE = 3'd0;
	localparam logic [2:0] SIZE_WORD = 3'd2;

	// Request types, OpenPiton encodings
	typedef enum logic [4:0]
	{
		LOAD_RQ  = 5'd0,
		STORE_RQ = 5'd1,
		IMISS_RQ = 5'd16
	} l15_rqtype_e;

	// Return types on the response side
	typedef enum logic [3:0]
	{
		LOAD_RET  = 4'd0,
		IFILL_RET = 4'd1,
		ST_ACK    = 4'd4
	} l15_rettype_e;

	// Load/store commands from the core
	typedef enum logic [2:0]
	{
		MEM_NONE = 3'd0,
		MEM_LB   = 3'd1,  // Sign-extended byte
		MEM_LBU  = 3'd2,  // Zero-extended byte
		MEM_LW   = 3'd3,
		MEM_SB   = 3'd4,
		MEM_SW   = 3'd5
	} mem_op_e;

	// Port arbiter states
	typedef enum logic [1:0]
	{
		ARB_INSTR = 2'd0,  // Fetch owns the port
		ARB_WAIT  = 2'd1,  // Draining fetch misses
		ARB_MEM   = 2'd2   // LSU owns the port
	} arb_state_e;

endpackage
